//--- hdl/routerPkg.sv
package routerPkg;

  // ****************************************
  // sizes
  // ****************************************
  localparam int numPorts     = 5;
  localparam int lenWidth     = 12;
  localparam int dataWidth    = 16;
  localparam int portIdxWidth = 3;
  localparam int stateWidth   = numPorts + 1;

  // ****************************************
  // encodings
  // ****************************************
  typedef enum logic [2:0] {
    flitNone = 3'd0,
    flitHead = 3'd1,
    flitBody = 3'd2,
    flitTail = 3'd3
  } flitKind;

  // bit 0 is idle, bits 1 to 5 follow the port order.
  typedef enum logic [stateWidth-1:0] {
    gIdle  = 6'b000001,
    gLocal = 6'b000010,
    gNorth = 6'b000100,
    gEast  = 6'b001000,
    gWest  = 6'b010000,
    gSouth = 6'b100000
  } grantState;

  typedef struct packed {
    logic                 req;
    flitKind              flitId;
    logic [lenWidth-1:0]  length;
    logic [dataWidth-1:0] data;
  } portIn;

  typedef struct packed {
    logic                    valid;
    logic [portIdxWidth-1:0] port;
    logic [dataWidth-1:0]    data;
  } flitOut;

  // returns 0 for gIdle, which callers must qualify themselves.
  function automatic logic [portIdxWidth-1:0] grantIndex(grantState g);
    logic [portIdxWidth-1:0] idx;
    idx = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (g[i+1])
        idx = portIdxWidth'(i);
    end
    return idx;
  endfunction

endpackage

//--- hdl/grantTimer.sv
`timescale 1ns/1ps

module grantTimer (
  input  logic                          clk,
  input  logic                          rst,
  input  routerPkg::flitKind            flitId,
  input  logic [routerPkg::lenWidth-1:0] length,
  input  logic                          runTimer,
  output logic                          timesUp
);

  logic [routerPkg::lenWidth-1:0] limit;
  logic [routerPkg::lenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == routerPkg::flitHead)
        limit <= length;  // a header loads the limit even without a grant.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;  // the count restarts with every new grant.
    end
  end

  assign timesUp = (count == limit);

  // the arbiter only runs the timer before it expires, so a running count
  // stays below the limit unless a header shrinks it during a grant.
  countBelowLimit: assert property (
    @(posedge clk) disable iff (rst)
    runTimer |-> (count < limit)
  ) else $error("grantTimer: count %0d passed limit %0d while running", count, limit);

endmodule

//--- hdl/rotatingArbiter.sv
`timescale 1ns/1ps

module rotatingArbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::portIn     ports [routerPkg::numPorts],
  output routerPkg::grantState grant
);

  logic [routerPkg::numPorts-1:0] reqVec;
  logic [routerPkg::numPorts-1:0] runTimer;
  logic [routerPkg::numPorts-1:0] timesUp;
  routerPkg::grantState           nextGrant;

  // ****************************************
  // per-port grant timers
  // ****************************************
  for (genvar p = 0; p < routerPkg::numPorts; p++)
  begin : timerGen
    assign reqVec[p] = ports[p].req;

    grantTimer i_grantTimer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (ports[p].flitId),
      .length   (ports[p].length),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  // ****************************************
  // grant state machine
  // ****************************************
  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= routerPkg::gIdle;
    else
      grant <= nextGrant;
  end

  always_comb
  begin : nextStateLogic
    int                              cur;
    int                              idx;
    logic [routerPkg::stateWidth-1:0] oneHot;
    oneHot   = routerPkg::gIdle;
    runTimer = '0;
    idx      = 0;
    cur      = int'(routerPkg::grantIndex(grant));
    if (grant == routerPkg::gIdle)
    begin
      // fixed order from idle, local first.
      for (int i = routerPkg::numPorts - 1; i >= 0; i--)
      begin
        if (reqVec[i])
          oneHot = routerPkg::stateWidth'(2) << i;
      end
    end
    else if (reqVec[cur] && !timesUp[cur])
    begin
      runTimer[cur] = 1'b1;  // hold the grant for one more cycle.
      oneHot        = grant;
    end
    else
    begin
      // rotate from the port after the current one. Lowest offset wins.
      for (int k = routerPkg::numPorts - 1; k >= 1; k--)
      begin
        idx = cur + k;
        if (idx >= routerPkg::numPorts)
          idx = idx - routerPkg::numPorts;
        if (reqVec[idx])
          oneHot = routerPkg::stateWidth'(2) << idx;
      end
      // an expired sole requester passes through idle before it is granted again.
    end
    nextGrant = routerPkg::grantState'(oneHot);
  end

  // ****************************************
  // checks
  // ****************************************
  legalGrant: assert property (
    @(posedge clk) disable iff (rst)
    grant inside {routerPkg::gIdle, routerPkg::gLocal, routerPkg::gNorth,
                  routerPkg::gEast, routerPkg::gWest, routerPkg::gSouth}
  ) else $error("rotatingArbiter: illegal grant %b", grant);

  singleRunTimer: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(runTimer)
  ) else $error("rotatingArbiter: several timers running %b", runTimer);

  runOnlyGranted: assert property (
    @(posedge clk) disable iff (rst)
    (|runTimer) |-> (runTimer == grant[routerPkg::numPorts:1])
  ) else $error("rotatingArbiter: timer %b runs for grant %b", runTimer, grant);

endmodule

//--- hdl/switchTraversal.sv
`timescale 1ns/1ps

module switchTraversal (
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::grantState grant,
  input  routerPkg::portIn     ports [routerPkg::numPorts],
  output routerPkg::flitOut    outFlit
);

  logic [routerPkg::portIdxWidth-1:0] selIdx;
  logic                               selHit;
  logic                               validQ;
  logic [routerPkg::portIdxWidth-1:0] portQ;
  logic [routerPkg::dataWidth-1:0]    dataQ;

  assign selIdx = routerPkg::grantIndex(grant);
  assign selHit = (grant != routerPkg::gIdle) && ports[selIdx].req;

  always_ff @(posedge clk)
  begin
    if (rst)
      validQ <= 1'b0;
    else
      validQ <= selHit;  // one pulse per flit moved.
  end

  always_ff @(posedge clk)
  begin
    if (selHit)
    begin
      portQ <= selIdx;
      dataQ <= ports[selIdx].data;
    end
  end

  assign outFlit = '{valid: validQ, port: portQ, data: dataQ};

  noFlitFromIdle: assert property (
    @(posedge clk) disable iff (rst)
    outFlit.valid |-> $past(grant != routerPkg::gIdle)
  ) else $error("switchTraversal: flit sent after an idle grant");

endmodule

//--- hdl/switchAllocTop.sv
`timescale 1ns/1ps

module switchAllocTop (
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::portIn     ports [routerPkg::numPorts],
  output routerPkg::grantState grant,
  output routerPkg::flitOut    outFlit
);

  // ****************************************
  // allocation
  // ****************************************
  rotatingArbiter i_rotatingArbiter (
    .clk   (clk),
    .rst   (rst),
    .ports (ports),
    .grant (grant)
  );

  // ****************************************
  // traversal
  // ****************************************
  switchTraversal i_switchTraversal (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .ports   (ports),
    .outFlit (outFlit)  // registered one cycle after the grant.
  );

endmodule

//--- bench/switchAllocTb.sv
`timescale 1ns/1ps

module switchAllocTb;

  logic                 clk;
  logic                 rst;
  routerPkg::portIn     ports [routerPkg::numPorts];
  routerPkg::grantState grant;
  routerPkg::flitOut    outFlit;

  logic [31:0] lfsrState = 32'ha01bfb4f;
  int          errCount = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          holdPorts [4] = '{0, 2, 4, 3};
  int          holdLens [4] = '{3, 1, 5, 0};

  int                             expPort;
  logic [routerPkg::lenWidth-1:0] limitM [routerPkg::numPorts];
  logic [routerPkg::lenWidth-1:0] countM [routerPkg::numPorts];
  logic                           expValid;
  logic [2:0]                     expOutPort;
  logic [15:0]                    expData;
  logic [5:0]                     expGrant;

  switchAllocTop i_switchAllocTop (
    .clk     (clk),
    .rst     (rst),
    .ports   (ports),
    .grant   (grant),
    .outFlit (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ****************************************
  // random source and stimulus helpers
  // ****************************************
  function automatic logic nextBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];  // taps 32, 22, 2, 1.
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], nextBit()};
    return v;
  endfunction

  function automatic int runCycleLimit();
    int total;
    total = 6 + 4;  // reset and the idle test.
    foreach (holdLens[i])
      total += 2 * holdLens[i] + 9;
    total += 19 + 10 + 204;
    return total + 50;
  endfunction

  task automatic drivePattern(logic [4:0] reqMask, routerPkg::flitKind kind, int len);
    for (int p = 0; p < routerPkg::numPorts; p++)
    begin
      ports[p].req    = reqMask[p];
      ports[p].flitId = reqMask[p] ? kind : routerPkg::flitNone;
      ports[p].length = routerPkg::lenWidth'(len);
      ports[p].data   = routerPkg::dataWidth'(randBits(routerPkg::dataWidth));
    end
  endtask

  task automatic reportTest(string name, int errBefore);
    testsRun++;
    if (errCount != errBefore)
    begin
      testsFailed++;
      $display("test %s: failed with %0d mismatches", name, errCount - errBefore);
    end
    else
      $display("test %s: ok", name);
  endtask

  // ****************************************
  // reference model
  // ****************************************
  assign expGrant = (expPort < 0) ? 6'b000001 : 6'(6'b000010 << expPort);

  always @(posedge clk)
  begin : refModel
    int nxt;
    bit hold;
    nxt  = -1;
    hold = 1'b0;
    if (rst)
    begin
      expPort  <= -1;
      expValid <= 1'b0;
      for (int p = 0; p < routerPkg::numPorts; p++)
      begin
        limitM[p] <= '0;
        countM[p] <= '0;
      end
    end
    else
    begin
      expValid <= 1'b0;
      if (expPort >= 0)
      begin
        if (ports[expPort].req)
        begin
          expValid   <= 1'b1;
          expOutPort <= 3'(expPort);
          expData    <= ports[expPort].data;
        end
      end
      if (expPort < 0)
      begin
        for (int p = 0; p < routerPkg::numPorts; p++)
          if (nxt < 0 && ports[p].req)
            nxt = p;
      end
      else if (ports[expPort].req && countM[expPort] != limitM[expPort])
      begin
        nxt  = expPort;
        hold = 1'b1;
      end
      else
      begin
        for (int k = 1; k < routerPkg::numPorts; k++)
          if (nxt < 0 && ports[(expPort + k) % routerPkg::numPorts].req)
            nxt = (expPort + k) % routerPkg::numPorts;
      end
      for (int p = 0; p < routerPkg::numPorts; p++)
      begin
        if (ports[p].flitId == routerPkg::flitHead)
          limitM[p] <= ports[p].length;
        countM[p] <= (hold && p == expPort) ? countM[p] + 1'b1 : '0;
      end
      expPort <= nxt;
    end
  end

  // ****************************************
  // checks
  // ****************************************
  grantCheck: assert property (@(posedge clk) disable iff (rst) grant == expGrant)
  else
  begin
    errCount++;
    $display("mismatch at %0t: grant %b, expected %b", $time, $sampled(grant),
             $sampled(expGrant));
  end

  validCheck: assert property (@(posedge clk) disable iff (rst) outFlit.valid == expValid)
  else
  begin
    errCount++;
    $display("mismatch at %0t: valid %b, expected %b", $time, $sampled(outFlit.valid),
             $sampled(expValid));
  end

  payloadCheck: assert property (
    @(posedge clk) disable iff (rst)
    expValid |-> (outFlit.port == expOutPort && outFlit.data == expData)
  )
  else
  begin
    errCount++;
    $display("mismatch at %0t: flit port %0d data %h, expected port %0d data %h", $time,
             $sampled(outFlit.port), $sampled(outFlit.data), $sampled(expOutPort),
             $sampled(expData));
  end

  initial
  begin : watchdog
    int cycleCount;
    int limit;
    cycleCount = 0;
    limit      = runCycleLimit();
    while (cycleCount < limit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

  // ****************************************
  // tests
  // ****************************************
  initial
  begin : stimulus
    int errBefore;
    rst = 1'b1;
    drivePattern(5'b00000, routerPkg::flitNone, 0);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    errBefore = errCount;
    repeat (4) @(negedge clk);
    reportTest("resetIdle", errBefore);

    errBefore = errCount;
    foreach (holdPorts[i])
    begin
      @(negedge clk);
      drivePattern(5'(1 << holdPorts[i]), routerPkg::flitHead, holdLens[i]);
      repeat (2 * (holdLens[i] + 2))
      begin
        @(negedge clk);
        drivePattern(5'(1 << holdPorts[i]), routerPkg::flitBody, 0);
      end
      @(negedge clk);
      drivePattern(5'b00000, routerPkg::flitNone, 0);
      repeat (3) @(negedge clk);
    end
    reportTest("singleHold", errBefore);

    errBefore = errCount;
    @(negedge clk);
    drivePattern(5'b11111, routerPkg::flitHead, 1);
    repeat (14)
    begin
      @(negedge clk);
      drivePattern(5'b11111, routerPkg::flitBody, 0);  // two cycles per port, then local again.
    end
    @(negedge clk);
    drivePattern(5'b00000, routerPkg::flitNone, 0);
    repeat (3) @(negedge clk);
    reportTest("roundRobin", errBefore);

    errBefore = errCount;
    @(negedge clk);
    drivePattern(5'b10101, routerPkg::flitHead, 6);
    repeat (2)
    begin
      @(negedge clk);
      drivePattern(5'b10101, routerPkg::flitBody, 0);
    end
    @(negedge clk);
    drivePattern(5'b10100, routerPkg::flitBody, 0);  // local leaves early, east is next.
    repeat (2)
    begin
      @(negedge clk);
      drivePattern(5'b10100, routerPkg::flitBody, 0);
    end
    @(negedge clk);
    drivePattern(5'b00000, routerPkg::flitNone, 0);
    repeat (3) @(negedge clk);
    reportTest("earlyDrop", errBefore);

    errBefore = errCount;
    repeat (200)
    begin
      @(negedge clk);
      drivePattern(5'(randBits(5)), routerPkg::flitBody, 0);
    end
    @(negedge clk);
    drivePattern(5'b00000, routerPkg::flitNone, 0);
    repeat (3) @(negedge clk);
    reportTest("randomTraffic", errBefore);

    $display("tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errCount);
    if (testsFailed == 0 && errCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- list.f
hdl/routerPkg.sv
hdl/grantTimer.sv
hdl/rotatingArbiter.sv
hdl/switchTraversal.sv
hdl/switchAllocTop.sv
bench/switchAllocTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the switch allocation testbench with Verilator.

cd "$(dirname "$0")" || exit 1

TOP=switchAllocTb
LOG=sim.log
FAIL_TEXT="FAIL: see errors above"

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f list.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0
